// File: include/vending_settings.svh
`ifndef VENDING_SETTINGS_SVH
`define VENDING_SETTINGS_SVH

// coin values in NTD
`define VALUE_NTD50 8'd50
`define VALUE_NTD10 8'd10
`define VALUE_NTD5  8'd5
`define VALUE_NTD1  8'd1

`define COST_A      8'd8
`define COST_B      8'd15
`define COST_C      8'd22

`define STOCK_INIT  3'd2  // per denomination after reset
`define STOCK_MAX   3'd7  // stock saturates here

`define COIN_IN_W   2     // inserted count width
`define COIN_OUT_W  3     // stock and coin-out count width
`define VALUE_W     8     // money value width

`endif

// File: logic/vendPkg.sv
package vendPkg;

  typedef enum logic [1:0] {
    IDLE     = 2'd0,  // waiting for a request
    CHECK    = 2'd1,  // money against cost
    DISPENSE = 2'd2,  // one coin per cycle
    FINISH   = 2'd3   // result on the ports
  } serviceState_t;

  // greedy order, largest first
  typedef enum logic [1:0] {
    NTD50 = 2'd0,
    NTD10 = 2'd1,
    NTD5  = 2'd2,
    NTD1  = 2'd3
  } coinType_t;

  typedef enum logic [1:0] {
    ITEM_NONE = 2'd0,
    ITEM_A    = 2'd1,
    ITEM_B    = 2'd2,
    ITEM_C    = 2'd3
  } item_t;

endpackage

// File: logic/serviceFsm.sv
module serviceFsm (
  input  logic               clk,
  input  logic               reset,
  input  logic               reqValid,
  input  logic               haveCoin,
  input  logic               fits,
  input  logic               short,
  output logic               deposit,
  output logic               take,
  output logic               refund,
  output logic               clearOut,
  output logic               load,
  output vendPkg::coinType_t coinSel,
  output logic               done,
  output logic               saleOk
);
  import vendPkg::*;

  serviceState_t state;
  serviceState_t nextState;
  coinType_t     nextSel;
  logic          nextSaleOk;

  always_comb begin
    nextState  = state;
    nextSel    = coinSel;
    nextSaleOk = saleOk;
    deposit    = 1'b0;
    take       = 1'b0;
    refund     = 1'b0;
    case (state)
      IDLE: begin
        if (reqValid) begin
          deposit    = 1'b1;  // bank and counter both latch the request
          nextSel    = NTD50;
          nextSaleOk = 1'b0;
          nextState  = CHECK;
        end
      end
      CHECK: begin
        if (short) begin
          refund    = 1'b1;  // not enough money or no item
          nextState = FINISH;
        end else begin
          nextState = DISPENSE;
        end
      end
      DISPENSE: begin
        if (fits && haveCoin) begin
          take = 1'b1;  // issue one coin, stay on this denomination
        end else if (coinSel != NTD1) begin
          nextSel = coinType_t'(coinSel + 2'd1);  // next smaller coin
        end else if (fits) begin
          // change left but no 1-coin to pay it
          refund    = 1'b1;
          nextState = FINISH;
        end else begin
          nextSaleOk = 1'b1;  // nothing fits at NTD1 so change is zero
          nextState  = FINISH;
        end
      end
      default: begin
        nextState = IDLE;  // FINISH lasts one cycle
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      state   <= IDLE;
      coinSel <= NTD50;
      saleOk  <= 1'b0;
    end else begin
      state   <= nextState;
      coinSel <= nextSel;
      saleOk  <= nextSaleOk;
    end
  end

  assign load     = deposit;
  assign done     = (state == FINISH);
  assign clearOut = done;  // coin-out counters empty after the result

endmodule

// File: logic/changeCounter.sv
`include "vending_settings.svh"

module changeCounter (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  load,
  input  logic                  take,
  input  vendPkg::coinType_t    coinSel,
  input  logic [`COIN_IN_W-1:0] coinIn50,
  input  logic [`COIN_IN_W-1:0] coinIn10,
  input  logic [`COIN_IN_W-1:0] coinIn5,
  input  logic [`COIN_IN_W-1:0] coinIn1,
  input  vendPkg::item_t        itemIn,
  output logic                  fits,
  output logic                  short,
  output vendPkg::item_t        itemHeld
);
  import vendPkg::*;

  logic [`VALUE_W-1:0] inValue;    // value of the coins on the ports
  logic [`VALUE_W-1:0] paid;       // value latched at load
  logic [`VALUE_W-1:0] change;     // change still owed
  logic [`VALUE_W-1:0] coinValue;  // value of the selected coin

  function automatic logic [`VALUE_W-1:0] costOf(item_t item);
    case (item)
      ITEM_A:  return `COST_A;
      ITEM_B:  return `COST_B;
      ITEM_C:  return `COST_C;
      default: return '0;
    endcase
  endfunction

  assign inValue = `VALUE_NTD50 * coinIn50 + `VALUE_NTD10 * coinIn10 +
                   `VALUE_NTD5 * coinIn5 + `VALUE_NTD1 * coinIn1;

  always_comb begin
    case (coinSel)
      NTD50:   coinValue = `VALUE_NTD50;
      NTD10:   coinValue = `VALUE_NTD10;
      NTD5:    coinValue = `VALUE_NTD5;
      default: coinValue = `VALUE_NTD1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      paid     <= '0;
      change   <= '0;
      itemHeld <= ITEM_NONE;
    end else if (load) begin
      paid     <= inValue;
      change   <= inValue - costOf(itemIn);  // wraps when short, never used then
      itemHeld <= itemIn;
    end else if (take) begin
      change <= change - coinValue;
    end
  end

  assign fits  = (change >= coinValue);
  assign short = (itemHeld == ITEM_NONE) || (paid < costOf(itemHeld));

endmodule

// File: logic/coinBank.sv
`include "vending_settings.svh"

module coinBank (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   deposit,
  input  logic                   take,
  input  logic                   refund,
  input  logic                   clearOut,
  input  vendPkg::coinType_t     coinSel,
  input  logic [`COIN_IN_W-1:0]  coinIn50,
  input  logic [`COIN_IN_W-1:0]  coinIn10,
  input  logic [`COIN_IN_W-1:0]  coinIn5,
  input  logic [`COIN_IN_W-1:0]  coinIn1,
  output logic                   haveCoin,
  output logic [`COIN_OUT_W-1:0] coinOut50,
  output logic [`COIN_OUT_W-1:0] coinOut10,
  output logic [`COIN_OUT_W-1:0] coinOut5,
  output logic [`COIN_OUT_W-1:0] coinOut1
);
  import vendPkg::*;

  logic [`COIN_OUT_W-1:0] stock    [4];  // coins held, indexed by coinType_t
  logic [`COIN_OUT_W-1:0] snapshot [4];  // stock before the deposit
  logic [`COIN_OUT_W-1:0] outCnt   [4];  // coins issued this request
  logic [`COIN_IN_W-1:0]  inCnt    [4];
  logic [`COIN_IN_W-1:0]  inHeld   [4];  // inserted counts for a refund
  logic [`COIN_OUT_W:0]   sum      [4];  // one extra bit for saturation

  always_comb begin
    inCnt[NTD50] = coinIn50;
    inCnt[NTD10] = coinIn10;
    inCnt[NTD5]  = coinIn5;
    inCnt[NTD1]  = coinIn1;
  end

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      sum[i] = {1'b0, stock[i]} + {{(`COIN_OUT_W + 1 - `COIN_IN_W){1'b0}}, inCnt[i]};
    end
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      for (int i = 0; i < 4; i++) begin
        stock[i]  <= `STOCK_INIT;
        outCnt[i] <= '0;
      end
    end else if (deposit) begin
      for (int i = 0; i < 4; i++) begin
        // extra coins beyond the bin limit are kept out of the count
        stock[i] <= (sum[i] > `STOCK_MAX) ? `STOCK_MAX : sum[i][`COIN_OUT_W-1:0];
      end
    end else if (take) begin
      stock[coinSel]  <= stock[coinSel] - 1'b1;
      outCnt[coinSel] <= outCnt[coinSel] + 1'b1;
    end else if (refund) begin
      for (int i = 0; i < 4; i++) begin
        stock[i]  <= snapshot[i];  // undo deposit and any issued coins
        outCnt[i] <= {{(`COIN_OUT_W - `COIN_IN_W){1'b0}}, inHeld[i]};
      end
    end else if (clearOut) begin
      for (int i = 0; i < 4; i++) begin
        outCnt[i] <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (deposit) begin
      for (int i = 0; i < 4; i++) begin
        snapshot[i] <= stock[i];
        inHeld[i]   <= inCnt[i];
      end
    end
  end

  assign haveCoin = (stock[coinSel] != '0);

  assign coinOut50 = outCnt[NTD50];
  assign coinOut10 = outCnt[NTD10];
  assign coinOut5  = outCnt[NTD5];
  assign coinOut1  = outCnt[NTD1];

endmodule

// File: logic/vendingMachine.sv
`include "vending_settings.svh"

module vendingMachine (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   reqValid,
  input  logic [`COIN_IN_W-1:0]  coinIn50,
  input  logic [`COIN_IN_W-1:0]  coinIn10,
  input  logic [`COIN_IN_W-1:0]  coinIn5,
  input  logic [`COIN_IN_W-1:0]  coinIn1,
  input  vendPkg::item_t         itemIn,
  output logic                   done,
  output vendPkg::item_t         itemOut,
  output logic [`COIN_OUT_W-1:0] coinOut50,
  output logic [`COIN_OUT_W-1:0] coinOut10,
  output logic [`COIN_OUT_W-1:0] coinOut5,
  output logic [`COIN_OUT_W-1:0] coinOut1
);
  import vendPkg::*;

  logic      deposit, take, refund, clearOut, load;
  logic      saleOk, haveCoin, fits, short;
  coinType_t coinSel;
  item_t     itemHeld;

  logic [`COIN_OUT_W-1:0] bankOut50, bankOut10, bankOut5, bankOut1;  // counters mid-dispense

  serviceFsm i_serviceFsm (
    .clk(clk), .reset(reset), .reqValid(reqValid),
    .haveCoin(haveCoin), .fits(fits), .short(short),
    .deposit(deposit), .take(take), .refund(refund), .clearOut(clearOut),
    .load(load), .coinSel(coinSel), .done(done), .saleOk(saleOk)
  );

  changeCounter i_changeCounter (
    .clk(clk), .reset(reset), .load(load), .take(take), .coinSel(coinSel),
    .coinIn50(coinIn50), .coinIn10(coinIn10), .coinIn5(coinIn5), .coinIn1(coinIn1),
    .itemIn(itemIn), .fits(fits), .short(short), .itemHeld(itemHeld)
  );

  coinBank i_coinBank (
    .clk(clk), .reset(reset), .deposit(deposit), .take(take), .refund(refund),
    .clearOut(clearOut), .coinSel(coinSel),
    .coinIn50(coinIn50), .coinIn10(coinIn10), .coinIn5(coinIn5), .coinIn1(coinIn1),
    .haveCoin(haveCoin),
    .coinOut50(bankOut50), .coinOut10(bankOut10), .coinOut5(bankOut5), .coinOut1(bankOut1)
  );

  // result only shows while done is high
  assign itemOut   = (done && saleOk) ? itemHeld : ITEM_NONE;
  assign coinOut50 = done ? bankOut50 : '0;
  assign coinOut10 = done ? bankOut10 : '0;
  assign coinOut5  = done ? bankOut5 : '0;
  assign coinOut1  = done ? bankOut1 : '0;

endmodule

// File: verif/vendClock.sv
module vendClock (
  output logic clk
);

  // period of 20
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

endmodule

// File: verif/vending_chk.sv
`include "vending_settings.svh"

module vendingChk (
  input logic                   clk,
  input logic                   reset,
  input logic                   reqValid,
  input logic [`COIN_IN_W-1:0]  coinIn50,
  input logic [`COIN_IN_W-1:0]  coinIn10,
  input logic [`COIN_IN_W-1:0]  coinIn5,
  input logic [`COIN_IN_W-1:0]  coinIn1,
  input vendPkg::item_t         itemIn,
  input logic                   done,
  input vendPkg::item_t         itemOut,
  input logic [`COIN_OUT_W-1:0] coinOut50,
  input logic [`COIN_OUT_W-1:0] coinOut10,
  input logic [`COIN_OUT_W-1:0] coinOut5,
  input logic [`COIN_OUT_W-1:0] coinOut1
);
  import vendPkg::*;

  int    errorCount = 0;  // assertion failures so far
  logic  busy;            // high from accept until the result, so not IDLE
  int    reqValue;        // money of the accepted request
  item_t reqItem;         // item of the accepted request
  int    outValue;

  function automatic int priceOf(item_t item);
    case (item)
      ITEM_A:  return `COST_A;
      ITEM_B:  return `COST_B;
      ITEM_C:  return `COST_C;
      default: return 0;
    endcase
  endfunction

  assign outValue = `VALUE_NTD50 * coinOut50 + `VALUE_NTD10 * coinOut10 +
                    `VALUE_NTD5 * coinOut5 + `VALUE_NTD1 * coinOut1;

  always_ff @(posedge clk) begin
    if (!reset) begin
      busy     <= 1'b0;
      reqValue <= 0;
      reqItem  <= ITEM_NONE;
    end else if (reqValid) begin
      busy     <= 1'b1;
      reqValue <= `VALUE_NTD50 * coinIn50 + `VALUE_NTD10 * coinIn10 +
                  `VALUE_NTD5 * coinIn5 + `VALUE_NTD1 * coinIn1;
      reqItem  <= itemIn;
    end else if (done) begin
      busy <= 1'b0;  // FSM back in IDLE after this edge
    end
  end

  donePulse: assert property (@(posedge clk) disable iff (!reset) done |=> !done)
    else begin
      $error("done held for two cycles");
      errorCount++;
    end

  reqInIdle: assert property (@(posedge clk) disable iff (!reset) reqValid |-> !busy)
    else begin
      $error("request while a sale is in progress");
      errorCount++;
    end

  // paid change must cover exactly the overpayment
  saleChange: assert property (@(posedge clk) disable iff (!reset)
    (done && itemOut != ITEM_NONE) |->
      ((itemOut == reqItem) && (outValue == reqValue - priceOf(reqItem))))
    else begin
      $error("sold item or change paid differs from the request");
      errorCount++;
    end

endmodule

bind vendingMachine vendingChk i_vendingChk (.*);

// File: verif/vendingTb.sv
`include "vending_settings.svh"

module vendingTb;
  import vendPkg::*;

  localparam int WAIT_LIMIT  = 100;  // cycles allowed per wait loop
  localparam int RANDOM_REQS = 200;

  logic                   clk;
  logic                   reset;
  logic                   reqValid;
  logic [`COIN_IN_W-1:0]  coinIn50, coinIn10, coinIn5, coinIn1;
  item_t                  itemIn;
  logic                   done;
  item_t                  itemOut;
  logic [`COIN_OUT_W-1:0] coinOut50, coinOut10, coinOut5, coinOut1;

  int          seed = 8920;
  int          credit;         // requester credit, one request in flight
  int          stockModel[4];  // reference stock in greedy order
  logic [13:0] expQ[$];        // item, then out counts 50 10 5 1
  string       nameQ[$];

  vendClock i_vendClock (.clk(clk));

  vendingMachine i_vendingMachine (
    .clk(clk), .reset(reset), .reqValid(reqValid),
    .coinIn50(coinIn50), .coinIn10(coinIn10), .coinIn5(coinIn5), .coinIn1(coinIn1),
    .itemIn(itemIn), .done(done), .itemOut(itemOut),
    .coinOut50(coinOut50), .coinOut10(coinOut10), .coinOut5(coinOut5), .coinOut1(coinOut1)
  );

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic compareValues(input string testName, input int expected, input int actual);
    if (expected !== actual) begin
      abortRun($sformatf("Fail %s: expected %0d, actual %0d", testName, expected, actual));
    end
  endtask

  // greedy change from the stock model, refund restores the stock
  function automatic logic [13:0] expectSale(input item_t item, input int inCnt[4]);
    int    snap[4];
    int    outCnt[4];
    int    values[4];
    int    paid;
    int    cost;
    int    change;
    bit    refundIt;
    item_t itemRes;
    values[0] = `VALUE_NTD50;
    values[1] = `VALUE_NTD10;
    values[2] = `VALUE_NTD5;
    values[3] = `VALUE_NTD1;
    paid = 0;
    for (int i = 0; i < 4; i++) begin
      snap[i]   = stockModel[i];
      outCnt[i] = 0;
      paid += values[i] * inCnt[i];
      stockModel[i] = stockModel[i] + inCnt[i];
      if (stockModel[i] > `STOCK_MAX) begin
        stockModel[i] = `STOCK_MAX;  // bin full
      end
    end
    case (item)
      ITEM_A:  cost = `COST_A;
      ITEM_B:  cost = `COST_B;
      ITEM_C:  cost = `COST_C;
      default: cost = 0;
    endcase
    refundIt = (item == ITEM_NONE) || (paid < cost);
    change   = paid - cost;
    for (int i = 0; i < 4 && !refundIt; i++) begin
      while (change >= values[i] && stockModel[i] > 0) begin
        change -= values[i];
        stockModel[i]--;
        outCnt[i]++;
      end
    end
    if (refundIt || change != 0) begin
      itemRes = ITEM_NONE;
      for (int i = 0; i < 4; i++) begin
        stockModel[i] = snap[i];
        outCnt[i]     = inCnt[i];
      end
    end else begin
      itemRes = item;
    end
    return {itemRes, 3'(outCnt[0]), 3'(outCnt[1]), 3'(outCnt[2]), 3'(outCnt[3])};
  endfunction

  task automatic sendRequest(input string name, input item_t item,
                             input int c50, input int c10, input int c5, input int c1);
    int waitCnt;
    int inCnt[4];
    waitCnt  = 0;
    inCnt[0] = c50;
    inCnt[1] = c10;
    inCnt[2] = c5;
    inCnt[3] = c1;
    @(posedge clk);
    while (credit == 0) begin
      waitCnt++;
      if (waitCnt > WAIT_LIMIT) begin
        abortRun($sformatf("timeout waiting for the credit before %s", name));
      end
      @(posedge clk);
    end
    reqValid <= 1'b1;
    coinIn50 <= c50;
    coinIn10 <= c10;
    coinIn5  <= c5;
    coinIn1  <= c1;
    itemIn   <= item;
    credit--;  // spent on this request
    expQ.push_back(expectSale(item, inCnt));
    nameQ.push_back(name);
    @(posedge clk);
    reqValid <= 1'b0;
  endtask

  initial begin : compareResults
    logic [13:0] expVal;
    string       testName;
    forever begin
      @(negedge clk);
      if (reset) begin
        if (i_vendingMachine.i_vendingChk.errorCount != 0) begin
          abortRun("a bound assertion on the vending machine failed");
        end
        if (done && expQ.size() == 0) begin
          abortRun("done came without an outstanding request");
        end else if (done) begin
          expVal   = expQ.pop_front();
          testName = nameQ.pop_front();
          compareValues({testName, " itemOut"}, expVal[13:12], itemOut);
          compareValues({testName, " coinOut50"}, expVal[11:9], coinOut50);
          compareValues({testName, " coinOut10"}, expVal[8:6], coinOut10);
          compareValues({testName, " coinOut5"}, expVal[5:3], coinOut5);
          compareValues({testName, " coinOut1"}, expVal[2:0], coinOut1);
          credit++;  // done hands the credit back
        end else begin
          compareValues("outputs between results", 0,
                        {itemOut, coinOut50, coinOut10, coinOut5, coinOut1});
        end
      end
    end
  end

  initial begin : runTests
    int    waitCnt;
    item_t randItem;
    int    randCnt[4];
    reset    <= 1'b0;
    reqValid <= 1'b0;
    coinIn50 <= '0;
    coinIn10 <= '0;
    coinIn5  <= '0;
    coinIn1  <= '0;
    itemIn   <= ITEM_NONE;
    credit    = 1;
    for (int i = 0; i < 4; i++) begin
      stockModel[i] = `STOCK_INIT;
    end
    repeat (4) @(posedge clk);
    reset <= 1'b1;
    @(negedge clk);
    compareValues("reset done", 0, done);
    compareValues("reset itemOut", ITEM_NONE, itemOut);
    compareValues("reset coin counts", 0, {coinOut50, coinOut10, coinOut5, coinOut1});

    sendRequest("exact B", ITEM_B, 0, 1, 1, 0);
    sendRequest("greedy past empty 10s", ITEM_A, 1, 0, 0, 0);  // uses all 10s, then 5s
    sendRequest("short money C", ITEM_C, 0, 1, 1, 1);
    sendRequest("no item", ITEM_NONE, 1, 2, 0, 3);
    sendRequest("no 1-coin change", ITEM_A, 0, 1, 0, 0);  // 1s are gone by now

    for (int n = 0; n < RANDOM_REQS; n++) begin
      randItem = item_t'($random(seed) & 3);
      for (int i = 0; i < 4; i++) begin
        randCnt[i] = $random(seed) & 3;
      end
      sendRequest($sformatf("random %0d", n), randItem,
                  randCnt[0], randCnt[1], randCnt[2], randCnt[3]);
    end

    waitCnt = 0;
    while (expQ.size() != 0) begin
      @(posedge clk);
      waitCnt++;
      if (waitCnt > WAIT_LIMIT) begin
        abortRun("timeout waiting for the last results");
      end
    end
    @(negedge clk);
    if (i_vendingMachine.i_vendingChk.errorCount == 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      abortRun("a bound assertion on the vending machine failed");
    end
  end

endmodule

// File: list.f
+incdir+include
logic/vendPkg.sv
logic/serviceFsm.sv
logic/changeCounter.sv
logic/coinBank.sv
logic/vendingMachine.sv
verif/vendClock.sv
verif/vending_chk.sv
verif/vendingTb.sv
